// ==== hdl/matmul_pkg.sv ====
package matmul_pkg;

  //////////////////////////////////////////////////
  // Tile geometry and memory timing
  //////////////////////////////////////////////////
  localparam int tile_size    = 4;
  localparam int data_width   = 8;
  localparam int addr_width   = 11;
  localparam int stride_width = 8;
  // Cycles from address to data on the operand memories
  localparam int mem_latency  = 1;
  // Operand register, product register and accumulator
  localparam int mac_cycles   = 3;
  localparam int count_width  = 8;

  typedef logic [data_width-1:0]           elem_t;
  // Lane i sits in bits [i*data_width +: data_width]
  typedef logic [tile_size*data_width-1:0] lane_vec_t;
  typedef logic [addr_width-1:0]           addr_t;
  typedef logic [stride_width-1:0]         stride_t;
  typedef logic [count_width-1:0]          cycle_t;

  // Last operand word arrives at tile_size + mem_latency, then lane skew and the
  // PE hops add 2*(tile_size-1) before the MAC pipeline settles the last sum
  localparam cycle_t capture_count =
    cycle_t'(tile_size + mem_latency + 2 * (tile_size - 1) + mac_cycles);
  // One C column leaves per cycle after the capture
  localparam cycle_t done_count = capture_count + cycle_t'(tile_size);

  typedef enum logic [1:0] {idle, run, done_wait} seq_state_t;

endpackage

// ==== hdl/tile_ctrl_if.sv ====
`timescale 1ns/10ps

// Phase signals from the sequencer to the operand feeders and the result drain
interface tile_ctrl_if;

  // Job active, low level clears the datapath
  logic                run;
  // Operand words are requested while this is high
  logic                feed;
  // Single cycle strobe when the C grid has settled
  logic                capture;
  // Cycles since the job started
  matmul_pkg::cycle_t  count;

  modport seq (
    output run, feed, capture, count
  );

  modport user (
    input run, feed, capture, count
  );

endinterface

// ==== hdl/processing_element.sv ====
`timescale 1ns/10ps

module processing_element (
  input  logic              clk,
  input  logic              clear,
  input  matmul_pkg::elem_t in_a,
  input  matmul_pkg::elem_t in_b,
  output matmul_pkg::elem_t out_a,
  output matmul_pkg::elem_t out_b,
  output matmul_pkg::elem_t out_c
);

  matmul_pkg::elem_t prod_q;

  //////////////////////////////////////////////////
  // Three stage wrapping MAC
  //////////////////////////////////////////////////
  // Stage 1 is the pass register pair, which also holds the multiplier operands.
  // Stage 2 keeps only the low byte of the product.
  // Stage 3 adds modulo 256 into the running sum
  always_ff @(posedge clk) begin
    if (clear) begin
      out_a  <= '0;
      out_b  <= '0;
      prod_q <= '0;
      out_c  <= '0;
    end else begin
      out_a  <= in_a;
      out_b  <= in_b;
      prod_q <= out_a * out_b;
      out_c  <= out_c + prod_q;
    end
  end

  // Zeros flow in outside the operand window, so a settled sum stays put
  // until the next clear

endmodule

// ==== hdl/pe_array.sv ====
`timescale 1ns/10ps

module pe_array (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  run,
  input  matmul_pkg::lane_vec_t a_lanes,
  input  matmul_pkg::lane_vec_t b_lanes,
  output matmul_pkg::elem_t     c_grid [matmul_pkg::tile_size][matmul_pkg::tile_size]
);

  localparam int n  = matmul_pkg::tile_size;
  localparam int dw = matmul_pkg::data_width;

  // a_link[i][j] enters PE (i,j) from the left, b_link[i][j] enters it from above
  matmul_pkg::elem_t a_link [n][n+1];
  matmul_pkg::elem_t b_link [n+1][n];
  logic              clear;

  // Every sum restarts when the job ends or start drops
  assign clear = reset || !run;

  for (genvar e = 0; e < n; e++) begin : g_edge
    assign a_link[e][0] = a_lanes[e*dw +: dw];
    assign b_link[0][e] = b_lanes[e*dw +: dw];
  end

  //////////////////////////////////////////////////
  // A moves right along rows, B moves down columns
  //////////////////////////////////////////////////
  for (genvar i = 0; i < n; i++) begin : g_row
    for (genvar j = 0; j < n; j++) begin : g_col
      processing_element i_pe (
        .clk   (clk),
        .clear (clear),
        .in_a  (a_link[i][j]),
        .in_b  (b_link[i][j]),
        .out_a (a_link[i][j+1]),
        .out_b (b_link[i+1][j]),
        .out_c (c_grid[i][j])
      );
    end
  end

endmodule

// ==== hdl/operand_feeder.sv ====
`timescale 1ns/10ps

module operand_feeder (
  input  logic                  clk,
  input  logic                  reset,
  tile_ctrl_if.user             ctrl,
  input  matmul_pkg::addr_t     base,
  input  matmul_pkg::stride_t   stride,
  output matmul_pkg::addr_t     mem_addr,
  input  matmul_pkg::lane_vec_t mem_data,
  output matmul_pkg::lane_vec_t lanes
);

  localparam int dw = matmul_pkg::data_width;

  // High in the cycles where mem_addr carries a requested word
  logic                              access;
  logic [matmul_pkg::mem_latency-1:0] valid_pipe;
  matmul_pkg::lane_vec_t              word;

  //////////////////////////////////////////////////
  // Read addresses and data qualification
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || !ctrl.run) begin
      mem_addr   <= base;
      access     <= 1'b0;
      valid_pipe <= '0;
    end else begin
      // The first request uses base, each later one adds a stride
      if (ctrl.feed && access) mem_addr <= mem_addr + matmul_pkg::addr_t'(stride);
      access        <= ctrl.feed;
      valid_pipe[0] <= access;
      for (int s = 1; s < matmul_pkg::mem_latency; s++) begin
        valid_pipe[s] <= valid_pipe[s-1];
      end
    end
  end

  // Words outside the read window enter the array as zeros
  assign word = mem_data & {matmul_pkg::tile_size * dw{valid_pipe[matmul_pkg::mem_latency-1]}};

  //////////////////////////////////////////////////
  // Lane i is delayed by i registers
  //////////////////////////////////////////////////
  for (genvar i = 0; i < matmul_pkg::tile_size; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign lanes[0 +: dw] = word[0 +: dw];
    end else begin : g_skew
      matmul_pkg::elem_t stage [i];
      always_ff @(posedge clk) begin
        if (reset || !ctrl.run) begin
          for (int s = 0; s < i; s++) stage[s] <= '0;
        end else begin
          stage[0] <= word[i*dw +: dw];
          for (int s = 1; s < i; s++) stage[s] <= stage[s-1];
        end
      end
      assign lanes[i*dw +: dw] = stage[i-1];
    end
  end

endmodule

// ==== hdl/result_drain.sv ====
`timescale 1ns/10ps

module result_drain (
  input  logic                  clk,
  input  logic                  reset,
  tile_ctrl_if.user             ctrl,
  input  matmul_pkg::elem_t     c_grid [matmul_pkg::tile_size][matmul_pkg::tile_size],
  input  matmul_pkg::addr_t     base,
  input  matmul_pkg::stride_t   stride,
  output matmul_pkg::addr_t     c_addr,
  output matmul_pkg::lane_vec_t c_data,
  output logic                  c_valid
);

  localparam int n  = matmul_pkg::tile_size;
  localparam int dw = matmul_pkg::data_width;

  // Column j of the grid as one memory word, lane i holding C[i][j]
  matmul_pkg::lane_vec_t grid_col [n];
  // Latched columns 1 to n-1 waiting for their write slot
  matmul_pkg::lane_vec_t col_q [n-1];
  logic                  more;

  always_comb begin
    for (int j = 0; j < n; j++) begin
      for (int i = 0; i < n; i++) begin
        grid_col[j][i*dw +: dw] = c_grid[i][j];
      end
    end
  end

  // Another column follows until the counter reaches the done point
  assign more = c_valid && (ctrl.count < matmul_pkg::done_count);

  always_ff @(posedge clk) begin
    if (reset || !ctrl.run) c_valid <= 1'b0;
    else c_valid <= ctrl.capture || more;
  end

  //////////////////////////////////////////////////
  // Column shift and write addresses
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (ctrl.capture) begin
      c_data <= grid_col[0];
      c_addr <= base;
      for (int j = 1; j < n; j++) col_q[j-1] <= grid_col[j];
    end else if (more) begin
      c_data <= col_q[0];
      c_addr <= c_addr + matmul_pkg::addr_t'(stride);
      for (int j = 1; j < n - 1; j++) col_q[j-1] <= col_q[j];
    end
  end

endmodule

// ==== hdl/tile_sequencer.sv ====
`timescale 1ns/10ps

module tile_sequencer (
  input  logic     clk,
  input  logic     reset,
  input  logic     start,
  output logic     done,
  tile_ctrl_if.seq ctrl
);

  matmul_pkg::seq_state_t state;
  matmul_pkg::cycle_t     count;
  logic                   active;

  // Count holds 0 on the first edge with start high, then steps once per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= matmul_pkg::idle;
      count <= '0;
    end else begin
      unique case (state)
        matmul_pkg::idle: begin
          count <= '0;
          if (start) state <= matmul_pkg::run;
        end
        matmul_pkg::run: begin
          // A dropped start aborts the job
          if (!start) state <= matmul_pkg::idle;
          else if (count == matmul_pkg::done_count) state <= matmul_pkg::done_wait;
          else count <= count + 1'b1;
        end
        matmul_pkg::done_wait: begin
          // Hold done until the requester releases start
          if (!start) state <= matmul_pkg::idle;
        end
        default: state <= matmul_pkg::idle;
      endcase
    end
  end

  // Run falls together with start so the datapath clears on the next edge
  assign active       = start && (state != matmul_pkg::idle);
  assign ctrl.run     = active;
  assign ctrl.feed    = active && (count < matmul_pkg::cycle_t'(matmul_pkg::tile_size));
  assign ctrl.capture = active && (count == matmul_pkg::capture_count);
  assign ctrl.count   = count;
  assign done         = (state == matmul_pkg::done_wait);

endmodule

// ==== hdl/matmul_tile.sv ====
`timescale 1ns/10ps

module matmul_tile (
  input  logic                  clk,
  input  logic                  reset,
  // Job handshake
  input  logic                  start,
  output logic                  done,
  // Base address and stride of each matrix
  input  matmul_pkg::addr_t     address_mat_a,
  input  matmul_pkg::addr_t     address_mat_b,
  input  matmul_pkg::addr_t     address_mat_c,
  input  matmul_pkg::stride_t   stride_a,
  input  matmul_pkg::stride_t   stride_b,
  input  matmul_pkg::stride_t   stride_c,
  // Operand memories, data one cycle after the address
  input  matmul_pkg::lane_vec_t a_data,
  input  matmul_pkg::lane_vec_t b_data,
  output matmul_pkg::addr_t     a_addr,
  output matmul_pkg::addr_t     b_addr,
  // Result writes, never stalled
  output matmul_pkg::addr_t     c_addr,
  output matmul_pkg::lane_vec_t c_data,
  output logic                  c_valid
);

  matmul_pkg::lane_vec_t a_lanes;
  matmul_pkg::lane_vec_t b_lanes;
  matmul_pkg::elem_t     c_grid [matmul_pkg::tile_size][matmul_pkg::tile_size];

  tile_ctrl_if i_ctrl ();

  tile_sequencer i_seq (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .done  (done),
    .ctrl  (i_ctrl)
  );

  //////////////////////////////////////////////////
  // A feeds the rows, B feeds the columns
  //////////////////////////////////////////////////
  operand_feeder i_feed_a (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (i_ctrl),
    .base     (address_mat_a),
    .stride   (stride_a),
    .mem_addr (a_addr),
    .mem_data (a_data),
    .lanes    (a_lanes)
  );

  operand_feeder i_feed_b (
    .clk      (clk),
    .reset    (reset),
    .ctrl     (i_ctrl),
    .base     (address_mat_b),
    .stride   (stride_b),
    .mem_addr (b_addr),
    .mem_data (b_data),
    .lanes    (b_lanes)
  );

  pe_array i_array (
    .clk     (clk),
    .reset   (reset),
    .run     (i_ctrl.run),
    .a_lanes (a_lanes),
    .b_lanes (b_lanes),
    .c_grid  (c_grid)
  );

  result_drain i_drain (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (i_ctrl),
    .c_grid  (c_grid),
    .base    (address_mat_c),
    .stride  (stride_c),
    .c_addr  (c_addr),
    .c_data  (c_data),
    .c_valid (c_valid)
  );

endmodule

// ==== testbench/tb_matmul_assert.sv ====
`timescale 1ns/10ps

module tb_matmul_assert (
  input logic                clk,
  input logic                reset,
  input logic                start,
  input logic                done,
  input matmul_pkg::addr_t   address_mat_a, address_mat_b, address_mat_c,
  input matmul_pkg::stride_t stride_a, stride_b, stride_c,
  input matmul_pkg::addr_t   a_addr, b_addr, c_addr,
  input logic                c_valid
);

  localparam int n = matmul_pkg::tile_size;
  // Edge count seen while column 0 is on the write port
  localparam int first_write = int'(matmul_pkg::capture_count) + 2;

  // Read by the testbench at the end of the run
  int assert_fails = 0;
  // Edges seen with start high, which is the job count of the current cycle plus one
  int job_edges;

  always_ff @(posedge clk) begin
    if (reset || !start) job_edges <= 0;
    else job_edges <= job_edges + 1;
  end

  //////////////////////////////////////////////////
  // Four phase handshake
  //////////////////////////////////////////////////
  a_done_hold: assert property (@(posedge clk) disable iff (reset) done && start |=> done)
    else begin
      $error("done fell while start was held");
      assert_fails++;
    end
  a_done_release: assert property (@(posedge clk) disable iff (reset) done && !start |=> !done)
    else begin
      $error("done stayed high after start dropped");
      assert_fails++;
    end
  a_no_job: assert property (@(posedge clk) disable iff (reset) !start && !done |=> !done)
    else begin
      $error("done rose without a job");
      assert_fails++;
    end
  // Exactly four writes end on the edge where done rises
  a_four_writes: assert property (@(posedge clk) disable iff (reset) $rose(done) |->
      !c_valid && $past(c_valid, 1) && $past(c_valid, 2) && $past(c_valid, 3)
      && $past(c_valid, 4) && !$past(c_valid, 5))
    else begin
      $error("done was not preceded by four writes");
      assert_fails++;
    end

  //////////////////////////////////////////////////
  // Strided read and write addresses
  //////////////////////////////////////////////////
  // Read k goes out at job count k+1
  a_read_a: assert property (@(posedge clk) disable iff (reset)
      job_edges >= 2 && job_edges <= n + 1
      |-> a_addr == address_mat_a + matmul_pkg::addr_t'(job_edges - 2)
                                    * matmul_pkg::addr_t'(stride_a))
    else begin
      $error("wrong A read address");
      assert_fails++;
    end
  a_read_b: assert property (@(posedge clk) disable iff (reset)
      job_edges >= 2 && job_edges <= n + 1
      |-> b_addr == address_mat_b + matmul_pkg::addr_t'(job_edges - 2)
                                    * matmul_pkg::addr_t'(stride_b))
    else begin
      $error("wrong B read address");
      assert_fails++;
    end
  // Column j goes out at job count capture_count+1+j
  a_write_c: assert property (@(posedge clk) disable iff (reset) c_valid
      |-> c_addr == address_mat_c + matmul_pkg::addr_t'(job_edges - first_write)
                                    * matmul_pkg::addr_t'(stride_c))
    else begin
      $error("wrong C write address");
      assert_fails++;
    end

endmodule

bind matmul_tile tb_matmul_assert i_checks (
  .clk (clk), .reset (reset), .start (start), .done (done),
  .address_mat_a (address_mat_a),
  .address_mat_b (address_mat_b),
  .address_mat_c (address_mat_c),
  .stride_a (stride_a), .stride_b (stride_b), .stride_c (stride_c),
  .a_addr (a_addr), .b_addr (b_addr), .c_addr (c_addr), .c_valid (c_valid)
);

// ==== testbench/tb_matmul_tile.sv ====
`timescale 1ns/10ps

module tb_matmul_tile;

  localparam int n           = matmul_pkg::tile_size;
  localparam int dw          = matmul_pkg::data_width;
  localparam int half_period = 20;
  localparam int job_count   = 4;
  // Every job plus handshake slack, and the reset and idle cycles
  localparam int limit_cycles = job_count * (int'(matmul_pkg::done_count) + 12) + 40;

  logic clk = 1'b0;
  logic reset;
  logic start;
  logic done;
  logic c_valid;
  matmul_pkg::addr_t     address_mat_a, address_mat_b, address_mat_c;
  matmul_pkg::stride_t   stride_a, stride_b, stride_c;
  matmul_pkg::addr_t     a_addr, b_addr, c_addr, a_req, b_req;
  matmul_pkg::lane_vec_t a_data, b_data, c_data;

  // Operand memories indexed by address
  matmul_pkg::lane_vec_t mem_a [2**matmul_pkg::addr_width];
  matmul_pkg::lane_vec_t mem_b [2**matmul_pkg::addr_width];
  matmul_pkg::elem_t     mat_a [n][n];
  matmul_pkg::elem_t     mat_b [n][n];
  matmul_pkg::elem_t     expect_c [n][n];
  logic [15:0]           lfsr = 16'd8;
  int tests = 0, failed_tests = 0, checks = 0, errors = 0, test_errors = 0;

  matmul_tile i_dut (.*);

  always #half_period clk = ~clk;

  // The address seen in a cycle is answered just after the following edge
  always @(negedge clk) begin
    a_req = a_addr;
    b_req = b_addr;
    @(posedge clk);
    #1;
    a_data = mem_a[a_req];
    b_data = mem_b[b_req];
  end

  //////////////////////////////////////////////////
  // Random source with taps x^16 + x^14 + x^13 + x^11 + 1
  //////////////////////////////////////////////////
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // Takes one LFSR step for each bit that goes into the value
  function automatic logic [7:0] random_bits(int bits);
    logic [7:0] value;
    value = '0;
    for (int b = 0; b < bits; b++) value = {value[6:0], lfsr_step()};
    return value;
  endfunction

  // Fills the matrices, places them in memory and works out C modulo 256
  task automatic load_job(input bit identity, input bit strided);
    matmul_pkg::lane_vec_t word;
    matmul_pkg::elem_t     acc;
    @(posedge clk);
    #1;
    for (int r = 0; r < n; r++) begin
      for (int k = 0; k < n; k++) begin
        mat_a[r][k] = identity ? ((r == k) ? 8'd1 : 8'd0) : random_bits(8);
        mat_b[r][k] = random_bits(8);
      end
    end
    address_mat_a = strided ? matmul_pkg::addr_t'({random_bits(3), random_bits(8)}) : '0;
    address_mat_b = strided ? matmul_pkg::addr_t'({random_bits(3), random_bits(8)}) : '0;
    address_mat_c = strided ? matmul_pkg::addr_t'({random_bits(3), random_bits(8)}) : '0;
    // Odd strides keep the four words of a matrix apart
    stride_a = strided ? (random_bits(8) | 8'd1) : 8'd1;
    stride_b = strided ? (random_bits(8) | 8'd1) : 8'd1;
    stride_c = strided ? (random_bits(8) | 8'd1) : 8'd1;
    for (int k = 0; k < n; k++) begin
      for (int l = 0; l < n; l++) word[l*dw +: dw] = mat_a[l][k];
      mem_a[matmul_pkg::addr_t'(address_mat_a + k * stride_a)] = word;
      for (int l = 0; l < n; l++) word[l*dw +: dw] = mat_b[k][l];
      mem_b[matmul_pkg::addr_t'(address_mat_b + k * stride_b)] = word;
    end
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        acc = '0;
        for (int k = 0; k < n; k++) acc = acc + mat_a[r][k] * mat_b[k][c];
        expect_c[r][c] = acc;
      end
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (test_errors != 0) failed_tests++;
    errors += test_errors;
    $display("%-12s %s, %0d errors", name, (test_errors == 0) ? "ok" : "wrong", test_errors);
    test_errors = 0;
  endtask

  // Raises start, compares each column as it is written, then releases the tile
  task automatic run_job(input string name);
    matmul_pkg::lane_vec_t expect_word;
    int col;
    col = 0;
    @(posedge clk);
    #1 start = 1'b1;
    do begin
      @(negedge clk);
      if (c_valid) begin
        for (int l = 0; l < n; l++) expect_word[l*dw +: dw] = expect_c[l][col % n];
        checks++;
        assert (c_data === expect_word) else begin
          $display("error %s column %0d: expected %h, actual %h",
                   name, col, expect_word, c_data);
          test_errors++;
        end
        col++;
      end
    end while (!done);
    assert (col == n) else begin
      $display("%s: the tile wrote %0d columns before done instead of %0d", name, col, n);
      test_errors++;
    end
    @(posedge clk);
    #1 start = 1'b0;
    do @(negedge clk); while (done);
    finish_test(name);
  endtask

  initial begin
    reset = 1'b1;
    start = 1'b0;
    address_mat_a = '0;
    address_mat_b = '0;
    address_mat_c = '0;
    stride_a = '0;
    stride_b = '0;
    stride_c = '0;
    a_data = '0;
    b_data = '0;
    // Background words that differ at every address
    for (int a = 0; a < 2**matmul_pkg::addr_width; a++) begin
      mem_a[a] = {5'h0b, matmul_pkg::addr_t'(a), 5'h13, matmul_pkg::addr_t'(a)};
      mem_b[a] = {5'h15, ~matmul_pkg::addr_t'(a), 5'h06, matmul_pkg::addr_t'(a)};
    end
    repeat (8) @(posedge clk);
    #1 reset = 1'b0;

    // Nothing may come out of an idle tile
    repeat (8) begin
      @(negedge clk);
      checks++;
      assert (done === 1'b0 && c_valid === 1'b0) else begin
        $display("error idle: expected done=0 c_valid=0, actual done=%b c_valid=%b",
                 done, c_valid);
        test_errors++;
      end
    end
    finish_test("idle");

    load_job(1'b1, 1'b0);
    run_job("identity");
    load_job(1'b0, 1'b0);
    run_job("random");
    load_job(1'b0, 1'b1);
    run_job("strided");
    // Second job right after a start drop so that any stale sum shows up here
    load_job(1'b0, 1'b1);
    run_job("back_to_back");

    repeat (2) @(posedge clk);
    errors += i_dut.i_checks.assert_fails;
    $display("%0d tests, %0d wrong, %0d checks, %0d errors, %0d assertion failures",
             tests, failed_tests, checks, errors, i_dut.i_checks.assert_fails);
    if (errors == 0 && failed_tests == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // Stops a tile that never answers the handshake
  initial begin
    #(limit_cycles * 2 * half_period);
    $display("watchdog: the jobs did not complete in %0d cycles", limit_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// ==== files.f ====
hdl/matmul_pkg.sv
hdl/tile_ctrl_if.sv
hdl/processing_element.sv
hdl/pe_array.sv
hdl/operand_feeder.sv
hdl/result_drain.sv
hdl/tile_sequencer.sv
hdl/matmul_tile.sv
testbench/tb_matmul_assert.sv
testbench/tb_matmul_tile.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_matmul_tile
FILELIST = files.f
LOG      = sim.log
FAIL_MSG = test failed
PASS_MSG = test passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
